// ==== hdl/r5p_alu.sv ====
`timescale 1ns/1ps

module r5p_alu #(
  // dedicated logic operand mux
  parameter bit CFG_LOM = 1'b0,
  // dedicated shift amount mux
  parameter bit CFG_SOM = 1'b1
)(
  input  r5p_pkg::opc_t            opc,
  input  logic [2:0]               fn3,
  input  logic                     fn7_5,
  input  logic [r5p_pkg::XLEN-1:0] pc,
  input  logic [r5p_pkg::XLEN-1:0] rs1,
  input  logic [r5p_pkg::XLEN-1:0] rs2,
  input  logic [r5p_pkg::XLEN-1:0] imm,
  output logic [r5p_pkg::XLEN-1:0] rd_val,
  // adder result with extension bit
  output logic [r5p_pkg::XLEN:0]   sum
);

  localparam int unsigned XLEN = r5p_pkg::XLEN;
  localparam int unsigned XLOG = $clog2(XLEN);

  // adder operands
  logic [XLEN-1:0] mux_op1;
  logic [XLEN-1:0] mux_op2;
  logic [XLEN:0]   add_op1;
  logic [XLEN:0]   add_op2;
  logic            add_inv;
  logic            sgn;
  // logic operands
  logic [XLEN-1:0] log_op1;
  logic [XLEN-1:0] log_op2;
  // shifter
  logic [XLOG-1:0] shf_sam;
  logic [XLEN-1:0] shf_tmp;
  logic [XLEN-1:0] shf_val;

  function automatic logic [XLEN-1:0] bitrev(input logic [XLEN-1:0] val);
    for (int i = 0; i < XLEN; i++) begin
      bitrev[i] = val[XLEN-1-i];
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////

  // operand select, also load/store address and auipc
  always_comb begin
    case (opc)
      r5p_pkg::OP,
      r5p_pkg::BRANCH: begin mux_op1 = rs1; mux_op2 = rs2; end
      r5p_pkg::JALR,
      r5p_pkg::LOAD,
      r5p_pkg::STORE,
      r5p_pkg::OP_IMM: begin mux_op1 = rs1; mux_op2 = imm; end
      r5p_pkg::AUIPC,
      r5p_pkg::JAL:    begin mux_op1 = pc;  mux_op2 = imm; end
      // lui passes imm through
      default:         begin mux_op1 = '0;  mux_op2 = imm; end
    endcase
  end

  // subtract for sub, slt and all compares
  always_comb begin
    add_inv = 1'b0;
    sgn     = 1'b0;
    case (opc)
      r5p_pkg::OP,
      r5p_pkg::OP_IMM: begin
        case (r5p_pkg::fn3_alu_t'(fn3))
          r5p_pkg::ADD:  begin add_inv = (opc == r5p_pkg::OP) & fn7_5; sgn = 1'b1; end
          r5p_pkg::SLT:  begin add_inv = 1'b1; sgn = 1'b1; end
          r5p_pkg::SLTU: begin add_inv = 1'b1; sgn = 1'b0; end
          default:       begin add_inv = 1'b0; sgn = 1'b0; end
        endcase
      end
      r5p_pkg::BRANCH: begin
        // signed only for blt/bge
        add_inv = 1'b1;
        sgn     = (fn3 == r5p_pkg::BLT) || (fn3 == r5p_pkg::BGE);
      end
      default: begin add_inv = 1'b0; sgn = 1'b0; end
    endcase
  end

  // one bit extension keeps the borrow
  assign add_op1 = sgn ? {mux_op1[XLEN-1], mux_op1} : {1'b0, mux_op1};
  assign add_op2 = sgn ? {mux_op2[XLEN-1], mux_op2} : {1'b0, mux_op2};

  // invert plus carry in gives two's complement
  assign sum = add_op1 + (add_inv ? ~add_op2 : add_op2) + (XLEN+1)'(add_inv);

  ////////////////////////////////////////////////////////////
  // logic and shift operands
  ////////////////////////////////////////////////////////////

  if (CFG_LOM) begin: gen_lom
    always_comb begin
      case (opc)
        r5p_pkg::OP:     begin log_op1 = rs1; log_op2 = rs2; end
        r5p_pkg::OP_IMM: begin log_op1 = rs1; log_op2 = imm; end
        default:         begin log_op1 = '0;  log_op2 = '0;  end
      endcase
    end
  end else begin: gen_lom_shared
    // reuse adder mux
    assign log_op1 = add_op1[XLEN-1:0];
    assign log_op2 = add_op2[XLEN-1:0];
  end

  if (CFG_SOM) begin: gen_som
    always_comb begin
      case (opc)
        r5p_pkg::OP:     shf_sam = rs2[XLOG-1:0];
        r5p_pkg::OP_IMM: shf_sam = imm[XLOG-1:0];
        default:         shf_sam = '0;
      endcase
    end
  end else begin: gen_som_shared
    assign shf_sam = log_op2[XLOG-1:0];
  end

  // left shift = reverse, shift right, reverse
  assign shf_tmp = (fn3 == r5p_pkg::SL) ? bitrev(rs1) : rs1;

  // sra fills with the sign bit
  always_comb begin
    if (fn7_5) begin
      shf_val = $signed(shf_tmp) >>> shf_sam;
    end else begin
      shf_val = shf_tmp >> shf_sam;
    end
  end

  ////////////////////////////////////////////////////////////
  // result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_val = sum[XLEN-1:0];
    if ((opc == r5p_pkg::OP) || (opc == r5p_pkg::OP_IMM)) begin
      case (r5p_pkg::fn3_alu_t'(fn3))
        r5p_pkg::ADD:  rd_val = sum[XLEN-1:0];
        // borrow bit is the compare
        r5p_pkg::SLT,
        r5p_pkg::SLTU: rd_val = XLEN'(sum[XLEN]);
        r5p_pkg::AND:  rd_val = log_op1 & log_op2;
        r5p_pkg::OR:   rd_val = log_op1 | log_op2;
        r5p_pkg::XOR:  rd_val = log_op1 ^ log_op2;
        r5p_pkg::SR:   rd_val = shf_val;
        r5p_pkg::SL:   rd_val = bitrev(shf_val);
        default:       rd_val = sum[XLEN-1:0];
      endcase
    end
  end

endmodule: r5p_alu

// ==== hdl/r5p_bru.sv ====
`timescale 1ns/1ps

module r5p_bru (
  input  r5p_pkg::opc_t            opc,
  input  logic [2:0]               fn3,
  // alu subtraction result
  input  logic [r5p_pkg::XLEN:0]   sum,
  input  logic [r5p_pkg::XLEN-1:0] pc,
  input  logic [r5p_pkg::XLEN-1:0] rs1,
  input  logic [r5p_pkg::XLEN-1:0] imm,
  output logic                     br_tkn,
  output logic [r5p_pkg::XLEN-1:0] br_tgt,
  output logic [r5p_pkg::XLEN-1:0] link
);

  localparam int unsigned XLEN = r5p_pkg::XLEN;

  logic            eq;
  logic            lt;
  logic [XLEN-1:0] jalr_adr;

  // rs1 - rs2 from the alu
  assign eq = (sum == '0);
  // borrow out, signedness already chosen in the alu
  assign lt = sum[XLEN];

  always_comb begin
    case (opc)
      r5p_pkg::BRANCH: begin
        case (r5p_pkg::fn3_bru_t'(fn3))
          r5p_pkg::BEQ:  br_tkn = eq;
          r5p_pkg::BNE:  br_tkn = ~eq;
          r5p_pkg::BLT,
          r5p_pkg::BLTU: br_tkn = lt;
          r5p_pkg::BGE,
          r5p_pkg::BGEU: br_tkn = ~lt;
          // reserved codes never branch
          default:       br_tkn = 1'b0;
        endcase
      end
      r5p_pkg::JAL,
      r5p_pkg::JALR: br_tkn = 1'b1;
      default:       br_tkn = 1'b0;
    endcase
  end

  // jalr target, lsb dropped
  assign jalr_adr = rs1 + imm;
  assign br_tgt   = (opc == r5p_pkg::JALR) ? {jalr_adr[XLEN-1:1], 1'b0} : pc + imm;

  // return address
  assign link = pc + XLEN'(4);

endmodule: r5p_bru

// ==== hdl/r5p_decoder.sv ====
`timescale 1ns/1ps

module r5p_decoder (
  // instruction word
  input  logic [31:0]              inst,
  // decoded fields
  output r5p_pkg::opc_t            opc,
  output logic [2:0]               fn3,
  output logic                     fn7_5,
  output logic [4:0]               rs1_adr,
  output logic [4:0]               rs2_adr,
  output logic [4:0]               rd_adr,
  output logic [r5p_pkg::XLEN-1:0] imm
);

  localparam int unsigned XLEN = r5p_pkg::XLEN;

  // immediates of each format, sign extended
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  ////////////////////////////////////////////////////////////
  // fixed position fields
  ////////////////////////////////////////////////////////////

  assign opc     = r5p_pkg::opc_t'(inst[6:0]);
  assign fn3     = inst[14:12];
  assign rd_adr  = inst[11:7];
  assign rs1_adr = inst[19:15];
  assign rs2_adr = inst[24:20];

  // bit 30 selects SUB and SRA
  // immediate ops other than SRAI carry imm bits there
  always_comb begin
    fn7_5 = inst[30];
    if ((opc == r5p_pkg::OP_IMM) && (fn3 != r5p_pkg::SR)) begin
      fn7_5 = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // immediate formats
  ////////////////////////////////////////////////////////////

  // I-type, jalr/load/op_imm
  assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
  // S-type, split around rd field
  assign imm_s = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  // B-type, halfword offset
  assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  // U-type, upper 20 bits
  assign imm_u = {inst[31:12], 12'b0};
  // J-type, halfword offset
  assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // format select by opcode
  always_comb begin
    case (opc)
      r5p_pkg::JALR,
      r5p_pkg::LOAD,
      r5p_pkg::OP_IMM: imm = imm_i;
      r5p_pkg::STORE:  imm = imm_s;
      r5p_pkg::BRANCH: imm = imm_b;
      r5p_pkg::LUI,
      r5p_pkg::AUIPC:  imm = imm_u;
      r5p_pkg::JAL:    imm = imm_j;
      // R-type has none
      default:         imm = '0;
    endcase
  end

endmodule: r5p_decoder

// ==== hdl/r5p_execute.sv ====
`timescale 1ns/1ps

module r5p_execute #(
  parameter bit CFG_LOM = 1'b0,
  parameter bit CFG_SOM = 1'b1
)(
  input  logic                     clk,
  input  logic                     arst_n,
  // instruction strobe
  input  logic                     inst_vld,
  input  logic [31:0]              inst,
  input  logic [r5p_pkg::XLEN-1:0] pc,
  // register write result
  output logic                     wb_vld,
  output logic [4:0]               wb_adr,
  output logic [r5p_pkg::XLEN-1:0] wb_dat,
  // branch/jump result
  output logic                     br_vld,
  output logic                     br_tkn,
  output logic [r5p_pkg::XLEN-1:0] br_tgt,
  // load/store address
  output logic                     mem_vld,
  output logic                     mem_wen,
  output logic [r5p_pkg::XLEN-1:0] mem_adr
);

  localparam int unsigned XLEN = r5p_pkg::XLEN;

  // decode
  r5p_pkg::opc_t   opc;
  logic [2:0]      fn3;
  logic            fn7_5;
  logic [4:0]      rs1_adr;
  logic [4:0]      rs2_adr;
  logic [4:0]      rd_adr;
  logic [XLEN-1:0] imm;
  // operands and results
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] rd_val;
  logic [XLEN:0]   sum;
  // branch unit, before the output register
  logic            bru_tkn;
  logic [XLEN-1:0] bru_tgt;
  logic [XLEN-1:0] link;
  // register file write
  logic            rf_wen;
  logic [4:0]      rf_wadr;
  logic [XLEN-1:0] rf_wdat;

  ////////////////////////////////////////////////////////////
  // combinational path
  ////////////////////////////////////////////////////////////

  r5p_decoder u_dec (
    .inst, .opc, .fn3, .fn7_5,
    .rs1_adr, .rs2_adr, .rd_adr, .imm
  );

  r5p_regfile u_rf (
    .clk, .arst_n,
    .rs1_adr, .rs2_adr, .rs1, .rs2,
    .rf_wen, .rf_wadr, .rf_wdat
  );

  r5p_alu #(
    .CFG_LOM (CFG_LOM),
    .CFG_SOM (CFG_SOM)
  ) u_alu (
    .opc, .fn3, .fn7_5,
    .pc, .rs1, .rs2, .imm,
    .rd_val, .sum
  );

  r5p_bru u_bru (
    .opc, .fn3, .sum, .pc, .rs1, .imm,
    .br_tkn (bru_tkn),
    .br_tgt (bru_tgt),
    .link
  );

  ////////////////////////////////////////////////////////////
  // writeback and output register
  ////////////////////////////////////////////////////////////

  r5p_writeback u_wb (
    .clk, .arst_n, .inst_vld, .opc, .rd_adr,
    .rd_val, .imm, .link,
    .br_tgt   (bru_tgt),
    .br_tkn   (bru_tkn),
    .sum,
    .rf_wen, .rf_wadr, .rf_wdat,
    .wb_vld, .wb_adr, .wb_dat,
    .br_vld,
    .br_tkn_q (br_tkn),
    .br_tgt_q (br_tgt),
    .mem_vld, .mem_wen, .mem_adr
  );

endmodule: r5p_execute

// ==== hdl/r5p_pkg.sv ====
package r5p_pkg;

  ////////////////////////////////////////////////////////////
  // data width
  ////////////////////////////////////////////////////////////

  // decoder handles RV32I only
  localparam int unsigned XLEN = 32;

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////

  // inst[6:0], low two bits always 2'b11
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opc_t;

  ////////////////////////////////////////////////////////////
  // function fields
  ////////////////////////////////////////////////////////////

  // alu function, inst[14:12] for OP and OP_IMM
  typedef enum logic [2:0] {
    ADD  = 3'b000,
    SL   = 3'b001,
    SLT  = 3'b010,
    SLTU = 3'b011,
    XOR  = 3'b100,
    SR   = 3'b101,
    OR   = 3'b110,
    AND  = 3'b111
  } fn3_alu_t;

  // branch condition, inst[14:12] for BRANCH
  // 3'b010 and 3'b011 are reserved
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } fn3_bru_t;

endpackage: r5p_pkg

// ==== hdl/r5p_regfile.sv ====
`timescale 1ns/1ps

module r5p_regfile (
  input  logic                     clk,
  input  logic                     arst_n,
  // read ports
  input  logic [4:0]               rs1_adr,
  input  logic [4:0]               rs2_adr,
  output logic [r5p_pkg::XLEN-1:0] rs1,
  output logic [r5p_pkg::XLEN-1:0] rs2,
  // write port
  input  logic                     rf_wen,
  input  logic [4:0]               rf_wadr,
  input  logic [r5p_pkg::XLEN-1:0] rf_wdat
);

  // x0..x31
  logic [r5p_pkg::XLEN-1:0] regs [0:31];

  // write at the edge, x0 never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_wen && (rf_wadr != 5'd0)) begin
      regs[rf_wadr] <= rf_wdat;
    end
  end

  // combinational reads
  // x0 hard wired
  assign rs1 = (rs1_adr == 5'd0) ? '0 : regs[rs1_adr];
  assign rs2 = (rs2_adr == 5'd0) ? '0 : regs[rs2_adr];

endmodule: r5p_regfile

// ==== hdl/r5p_writeback.sv ====
`timescale 1ns/1ps

module r5p_writeback (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     inst_vld,
  input  r5p_pkg::opc_t            opc,
  input  logic [4:0]               rd_adr,
  input  logic [r5p_pkg::XLEN-1:0] rd_val,
  input  logic [r5p_pkg::XLEN-1:0] imm,
  input  logic [r5p_pkg::XLEN-1:0] link,
  input  logic [r5p_pkg::XLEN-1:0] br_tgt,
  input  logic                     br_tkn,
  input  logic [r5p_pkg::XLEN:0]   sum,
  // register file write
  output logic                     rf_wen,
  output logic [4:0]               rf_wadr,
  output logic [r5p_pkg::XLEN-1:0] rf_wdat,
  // registered strobes
  output logic                     wb_vld,
  output logic [4:0]               wb_adr,
  output logic [r5p_pkg::XLEN-1:0] wb_dat,
  output logic                     br_vld,
  output logic                     br_tkn_q,
  output logic [r5p_pkg::XLEN-1:0] br_tgt_q,
  output logic                     mem_vld,
  output logic                     mem_wen,
  output logic [r5p_pkg::XLEN-1:0] mem_adr
);

  logic rd_wr;
  logic is_br;
  logic is_mem;

  // destination value by opcode
  always_comb begin
    case (opc)
      r5p_pkg::LUI:      begin rd_wr = 1'b1; rf_wdat = imm;    end
      r5p_pkg::JAL,
      r5p_pkg::JALR:     begin rd_wr = 1'b1; rf_wdat = link;   end
      r5p_pkg::OP,
      r5p_pkg::OP_IMM,
      r5p_pkg::AUIPC:    begin rd_wr = 1'b1; rf_wdat = rd_val; end
      // branch, load, store
      default:           begin rd_wr = 1'b0; rf_wdat = rd_val; end
    endcase
  end

  // lands at the same edge that samples inst_vld
  assign rf_wen  = inst_vld & rd_wr & (rd_adr != 5'd0);
  assign rf_wadr = rd_adr;

  assign is_br  = inst_vld & ((opc == r5p_pkg::BRANCH) || (opc == r5p_pkg::JAL) ||
                              (opc == r5p_pkg::JALR));
  assign is_mem = inst_vld & ((opc == r5p_pkg::LOAD) || (opc == r5p_pkg::STORE));

  ////////////////////////////////////////////////////////////
  // output register, one cycle after inst_vld
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_vld   <= 1'b0;
      wb_adr   <= '0;
      wb_dat   <= '0;
      br_vld   <= 1'b0;
      br_tkn_q <= 1'b0;
      br_tgt_q <= '0;
      mem_vld  <= 1'b0;
      mem_wen  <= 1'b0;
      mem_adr  <= '0;
    end else begin
      // strobes every cycle
      wb_vld  <= rf_wen;
      br_vld  <= is_br;
      mem_vld <= is_mem;
      mem_wen <= is_mem & (opc == r5p_pkg::STORE);
      // payload held between strobes
      if (rf_wen) begin
        wb_adr <= rd_adr;
        wb_dat <= rf_wdat;
      end
      if (is_br) begin
        br_tkn_q <= br_tkn;
        br_tgt_q <= br_tgt;
      end
      if (is_mem) begin
        mem_adr <= sum[r5p_pkg::XLEN-1:0];
      end
    end
  end

endmodule: r5p_writeback

// ==== r5p_execute.f ====
hdl/r5p_pkg.sv
hdl/r5p_decoder.sv
hdl/r5p_regfile.sv
hdl/r5p_alu.sv
hdl/r5p_bru.sv
hdl/r5p_writeback.sv
hdl/r5p_execute.sv
tb/r5p_execute_assert.sv
tb/r5p_execute_checker.sv
tb/r5p_execute_tb.sv

// ==== tb/r5p_execute_assert.sv ====
`timescale 1ns/1ps

module r5p_execute_assert (
  input logic       clk,
  input logic       arst_n,
  input logic       wb_vld,
  input logic [4:0] wb_adr,
  input logic       br_vld,
  input logic       mem_vld
);

  // failed assertion count
  int fail_cnt = 0;

  // strobes cleared while in reset
  a_rst_quiet: assert property (@(posedge clk) !arst_n |-> !wb_vld && !br_vld && !mem_vld)
    else begin
      fail_cnt++;
      $error("strobe high during reset");
    end

  // x0 is never reported as written
  a_no_x0: assert property (@(posedge clk) disable iff (!arst_n) wb_vld |-> (wb_adr != 5'd0))
    else begin
      fail_cnt++;
      $error("wb_vld with wb_adr zero");
    end

  // one instruction is either a jump/branch or a memory op
  a_br_mem: assert property (@(posedge clk) disable iff (!arst_n) !(br_vld && mem_vld))
    else begin
      fail_cnt++;
      $error("br_vld and mem_vld high together");
    end

endmodule: r5p_execute_assert

bind r5p_execute r5p_execute_assert u_assert (
  .clk     (clk),
  .arst_n  (arst_n),
  .wb_vld  (wb_vld),
  .wb_adr  (wb_adr),
  .br_vld  (br_vld),
  .mem_vld (mem_vld)
);

// ==== tb/r5p_execute_checker.sv ====
`timescale 1ns/1ps

module r5p_execute_checker (
  input  logic                     clk,
  input  logic                     arst_n,
  // dut outputs
  input  logic                     wb_vld,
  input  logic [4:0]               wb_adr,
  input  logic [r5p_pkg::XLEN-1:0] wb_dat,
  input  logic                     br_vld,
  input  logic                     br_tkn,
  input  logic [r5p_pkg::XLEN-1:0] br_tgt,
  input  logic                     mem_vld,
  input  logic                     mem_wen,
  input  logic [r5p_pkg::XLEN-1:0] mem_adr,
  // expected row, aligned with the output register
  input  logic                     chk_vld,
  input  int                       chk_idx,
  input  logic                     exp_wb_vld,
  input  logic [4:0]               exp_wb_adr,
  input  logic [r5p_pkg::XLEN-1:0] exp_wb_dat,
  input  logic                     exp_br_vld,
  input  logic                     exp_br_tkn,
  input  logic [r5p_pkg::XLEN-1:0] exp_br_tgt,
  input  logic                     exp_mem_vld,
  input  logic                     exp_mem_wen,
  input  logic [r5p_pkg::XLEN-1:0] exp_mem_adr,
  // counts
  output int                       rows_seen,
  output int                       rows_pass,
  output int                       rows_fail,
  output int                       idle_err
);

  // mismatches in the current row
  int bad;

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      bad++;
      $display("Fail at %0t: row %0d %s is %h, expected %h", $time, chk_idx, name, got, exp);
    end
  endtask

  initial begin
    rows_seen = 0;
    rows_pass = 0;
    rows_fail = 0;
    idle_err  = 0;
    bad       = 0;
  end

  // sampled mid cycle, away from the driving edge
  always @(negedge clk) begin
    if (arst_n && chk_vld) begin
      bad = 0;
      check_field("wb_vld", wb_vld, exp_wb_vld);
      check_field("br_vld", br_vld, exp_br_vld);
      check_field("mem_vld", mem_vld, exp_mem_vld);
      // payloads only mean something under their strobe
      if (exp_wb_vld) begin
        check_field("wb_adr", wb_adr, exp_wb_adr);
        check_field("wb_dat", wb_dat, exp_wb_dat);
      end
      if (exp_br_vld) begin
        check_field("br_tkn", br_tkn, exp_br_tkn);
        check_field("br_tgt", br_tgt, exp_br_tgt);
      end
      if (exp_mem_vld) begin
        check_field("mem_wen", mem_wen, exp_mem_wen);
        check_field("mem_adr", mem_adr, exp_mem_adr);
      end
      rows_seen++;
      if (bad == 0) begin
        rows_pass++;
        $display("row %0d ok", chk_idx);
      end else begin
        rows_fail++;
        $display("row %0d bad, %0d mismatches", chk_idx, bad);
      end
    end else if (arst_n && (wb_vld || br_vld || mem_vld)) begin
      // nothing in flight, strobes must be quiet
      idle_err++;
      $display("Fail at %0t: strobe high with no instruction in flight", $time);
    end
  end

endmodule: r5p_execute_checker

// ==== tb/r5p_execute_tb.sv ====
`timescale 1ns/1ps

module r5p_execute_tb;

  localparam int unsigned XLEN = r5p_pkg::XLEN;
  localparam int RST_CYCLES = 10;
  localparam int MAX_ROWS = 64;
  // slack beyond reset and table length
  localparam int SLACK_CYCLES = 20;

  // dut inputs
  logic            clk;
  logic            arst_n;
  logic            inst_vld;
  logic [31:0]     inst;
  logic [XLEN-1:0] pc;
  // dut outputs
  logic            wb_vld;
  logic [4:0]      wb_adr;
  logic [XLEN-1:0] wb_dat;
  logic            br_vld;
  logic            br_tkn;
  logic [XLEN-1:0] br_tgt;
  logic            mem_vld;
  logic            mem_wen;
  logic [XLEN-1:0] mem_adr;

  // stimulus and expected values, one row per instruction
  logic [31:0]     t_inst    [0:MAX_ROWS-1];
  logic [XLEN-1:0] t_pc      [0:MAX_ROWS-1];
  logic            e_wb_vld  [0:MAX_ROWS-1];
  logic [4:0]      e_wb_adr  [0:MAX_ROWS-1];
  logic [XLEN-1:0] e_wb_dat  [0:MAX_ROWS-1];
  logic            e_br_vld  [0:MAX_ROWS-1];
  logic            e_br_tkn  [0:MAX_ROWS-1];
  logic [XLEN-1:0] e_br_tgt  [0:MAX_ROWS-1];
  logic            e_mem_vld [0:MAX_ROWS-1];
  logic            e_mem_wen [0:MAX_ROWS-1];
  logic [XLEN-1:0] e_mem_adr [0:MAX_ROWS-1];
  int              n_rows;
  logic [XLEN-1:0] row_pc;
  logic [XLEN-1:0] link_pc;

  // row index in flight, then delayed to match the output register
  logic            cur_vld;
  int              cur_idx;
  logic            chk_vld;
  int              chk_idx;

  // checker results
  int              rows_seen;
  int              rows_pass;
  int              rows_fail;
  int              idle_err;
  int              cycles;

  r5p_execute #(
    .CFG_LOM (1'b0),
    .CFG_SOM (1'b1)
  ) uut (
    .clk, .arst_n, .inst_vld, .inst, .pc,
    .wb_vld, .wb_adr, .wb_dat,
    .br_vld, .br_tkn, .br_tgt,
    .mem_vld, .mem_wen, .mem_adr
  );

  r5p_execute_checker u_chk (
    .clk, .arst_n,
    .wb_vld, .wb_adr, .wb_dat,
    .br_vld, .br_tkn, .br_tgt,
    .mem_vld, .mem_wen, .mem_adr,
    .chk_vld, .chk_idx,
    .exp_wb_vld  (e_wb_vld[chk_idx]),
    .exp_wb_adr  (e_wb_adr[chk_idx]),
    .exp_wb_dat  (e_wb_dat[chk_idx]),
    .exp_br_vld  (e_br_vld[chk_idx]),
    .exp_br_tkn  (e_br_tkn[chk_idx]),
    .exp_br_tgt  (e_br_tgt[chk_idx]),
    .exp_mem_vld (e_mem_vld[chk_idx]),
    .exp_mem_wen (e_mem_wen[chk_idx]),
    .exp_mem_adr (e_mem_adr[chk_idx]),
    .rows_seen, .rows_pass, .rows_fail, .idle_err
  );

  ////////////////////////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////////////////////////

  // register-register, always OP
  function automatic logic [31:0] r_type(input logic [6:0] fn7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] fn3,
                                         input logic [4:0] rd);
    r_type = {fn7, rs2, rs1, fn3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] fn3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    i_type = {imm, rs1, fn3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] fn3);
    s_type = {imm[11:5], rs2, rs1, fn3, imm[4:0], 7'b0100011};
  endfunction

  // offset in bytes, bit 0 dropped
  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] fn3);
    b_type = {off[12], off[10:5], rs2, rs1, fn3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    u_type = {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    j_type = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  ////////////////////////////////////////////////////////////
  // table rows
  ////////////////////////////////////////////////////////////

  task automatic store_row(input logic [31:0] ins, input logic wbv, input logic [XLEN-1:0] wbd,
                           input logic brv, input logic brt, input logic [XLEN-1:0] brg,
                           input logic mv, input logic mw, input logic [XLEN-1:0] ma);
    t_inst[n_rows]    = ins;
    t_pc[n_rows]      = row_pc;
    e_wb_vld[n_rows]  = wbv;
    e_wb_adr[n_rows]  = ins[11:7];
    e_wb_dat[n_rows]  = wbd;
    e_br_vld[n_rows]  = brv;
    e_br_tkn[n_rows]  = brt;
    e_br_tgt[n_rows]  = brg;
    e_mem_vld[n_rows] = mv;
    e_mem_wen[n_rows] = mw;
    e_mem_adr[n_rows] = ma;
    n_rows++;
    // sequential pc, 4 bytes per instruction
    row_pc = row_pc + 32'd4;
  endtask

  task automatic wb_row(input logic [31:0] ins, input logic [XLEN-1:0] dat);
    store_row(ins, 1'b1, dat, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic branch_row(input logic [31:0] ins, input logic tkn, input logic [XLEN-1:0] tgt);
    store_row(ins, 1'b0, '0, 1'b1, tkn, tgt, 1'b0, 1'b0, '0);
  endtask

  // jal/jalr write the link and always take
  task automatic jump_row(input logic [31:0] ins, input logic [XLEN-1:0] lnk,
                          input logic [XLEN-1:0] tgt);
    store_row(ins, 1'b1, lnk, 1'b1, 1'b1, tgt, 1'b0, 1'b0, '0);
  endtask

  task automatic mem_row(input logic [31:0] ins, input logic wen, input logic [XLEN-1:0] adr);
    store_row(ins, 1'b0, '0, 1'b0, 1'b0, '0, 1'b1, wen, adr);
  endtask

  task automatic silent_row(input logic [31:0] ins);
    store_row(ins, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic build_table();
    n_rows = 0;
    row_pc = 32'h0000_0100;
    // x1 = 5, x2 = -3, x3 = 0x7ff, x4 = 5
    wb_row(i_type(12'd5, 5'd0, r5p_pkg::ADD, 5'd1, r5p_pkg::OP_IMM), 32'd5);
    wb_row(i_type(-12'sd3, 5'd0, r5p_pkg::ADD, 5'd2, r5p_pkg::OP_IMM), 32'hFFFF_FFFD);
    wb_row(i_type(12'h7FF, 5'd0, r5p_pkg::ADD, 5'd3, r5p_pkg::OP_IMM), 32'h0000_07FF);
    wb_row(i_type(12'd5, 5'd0, r5p_pkg::ADD, 5'd4, r5p_pkg::OP_IMM), 32'd5);
    // register-register arithmetic and logic
    wb_row(r_type(7'h00, 5'd2, 5'd1, r5p_pkg::ADD, 5'd5), 32'd2);
    wb_row(r_type(7'h20, 5'd2, 5'd1, r5p_pkg::ADD, 5'd6), 32'd8);
    wb_row(r_type(7'h00, 5'd3, 5'd1, r5p_pkg::AND, 5'd7), 32'd5);
    wb_row(r_type(7'h00, 5'd3, 5'd2, r5p_pkg::OR, 5'd8), 32'hFFFF_FFFF);
    wb_row(r_type(7'h00, 5'd2, 5'd1, r5p_pkg::XOR, 5'd9), 32'hFFFF_FFF8);
    // negative operand, signed vs unsigned
    wb_row(r_type(7'h00, 5'd1, 5'd2, r5p_pkg::SLT, 5'd10), 32'd1);
    wb_row(r_type(7'h00, 5'd1, 5'd2, r5p_pkg::SLTU, 5'd11), 32'd0);
    wb_row(r_type(7'h00, 5'd2, 5'd1, r5p_pkg::SLT, 5'd12), 32'd0);
    wb_row(r_type(7'h00, 5'd2, 5'd1, r5p_pkg::SLTU, 5'd13), 32'd1);
    // shifts by rs2[4:0]
    wb_row(r_type(7'h00, 5'd1, 5'd1, r5p_pkg::SL, 5'd14), 32'h0000_00A0);
    wb_row(r_type(7'h00, 5'd1, 5'd2, r5p_pkg::SR, 5'd15), 32'h07FF_FFFF);
    wb_row(r_type(7'h20, 5'd1, 5'd2, r5p_pkg::SR, 5'd16), 32'hFFFF_FFFF);
    // 0x7ff shifts by 31 only
    wb_row(r_type(7'h00, 5'd3, 5'd1, r5p_pkg::SL, 5'd20), 32'h8000_0000);
    // immediate shifts
    wb_row(i_type({7'h00, 5'd4}, 5'd3, r5p_pkg::SL, 5'd17, r5p_pkg::OP_IMM), 32'h0000_7FF0);
    wb_row(i_type({7'h00, 5'd28}, 5'd2, r5p_pkg::SR, 5'd18, r5p_pkg::OP_IMM), 32'h0000_000F);
    wb_row(i_type({7'h20, 5'd1}, 5'd2, r5p_pkg::SR, 5'd19, r5p_pkg::OP_IMM), 32'hFFFF_FFFE);
    // immediate compare and logic
    wb_row(i_type(-12'sd2, 5'd2, r5p_pkg::SLT, 5'd21, r5p_pkg::OP_IMM), 32'd1);
    wb_row(i_type(-12'sd1, 5'd1, r5p_pkg::SLTU, 5'd22, r5p_pkg::OP_IMM), 32'd1);
    wb_row(i_type(-12'sd1, 5'd1, r5p_pkg::XOR, 5'd23, r5p_pkg::OP_IMM), 32'hFFFF_FFFA);
    wb_row(i_type(12'h0F0, 5'd2, r5p_pkg::AND, 5'd24, r5p_pkg::OP_IMM), 32'h0000_00F0);
    wb_row(i_type(12'h100, 5'd1, r5p_pkg::OR, 5'd25, r5p_pkg::OP_IMM), 32'h0000_0105);
    // reads x25 right after its write
    wb_row(r_type(7'h00, 5'd24, 5'd25, r5p_pkg::ADD, 5'd25), 32'h0000_01F5);
    ////////////////////////////////////////////////////////////
    // branches, target is pc + offset either way
    branch_row(b_type(13'd16, 5'd4, 5'd1, r5p_pkg::BEQ), 1'b1, row_pc + 32'd16);
    branch_row(b_type(13'd16, 5'd2, 5'd1, r5p_pkg::BEQ), 1'b0, row_pc + 32'd16);
    branch_row(b_type(-13'sd8, 5'd2, 5'd1, r5p_pkg::BNE), 1'b1, row_pc - 32'd8);
    branch_row(b_type(13'd32, 5'd1, 5'd2, r5p_pkg::BLT), 1'b1, row_pc + 32'd32);
    branch_row(b_type(13'd32, 5'd2, 5'd1, r5p_pkg::BLT), 1'b0, row_pc + 32'd32);
    branch_row(b_type(13'd12, 5'd2, 5'd1, r5p_pkg::BGE), 1'b1, row_pc + 32'd12);
    branch_row(b_type(13'd12, 5'd1, 5'd2, r5p_pkg::BGE), 1'b0, row_pc + 32'd12);
    branch_row(b_type(13'd20, 5'd1, 5'd2, r5p_pkg::BLTU), 1'b0, row_pc + 32'd20);
    branch_row(b_type(13'd20, 5'd1, 5'd2, r5p_pkg::BGEU), 1'b1, row_pc + 32'd20);
    branch_row(b_type(-13'sd16, 5'd2, 5'd1, r5p_pkg::BLTU), 1'b1, row_pc - 32'd16);
    // jumps
    jump_row(j_type(21'd2048, 5'd26), row_pc + 32'd4, row_pc + 32'h0000_0800);
    link_pc = row_pc + 32'd4;
    // 5 + 0x20 is odd, target drops bit 0
    jump_row(i_type(12'h020, 5'd1, 3'b000, 5'd27, r5p_pkg::JALR), link_pc, 32'h0000_0024);
    // upper immediates
    wb_row(u_type(20'hABCDE, 5'd28, r5p_pkg::LUI), 32'hABCD_E000);
    wb_row(u_type(20'h12345, 5'd29, r5p_pkg::AUIPC), row_pc + 32'h1234_5000);
    // x29 + 4 lands on this row's pc plus the same offset
    wb_row(i_type(12'd4, 5'd29, r5p_pkg::ADD, 5'd30, r5p_pkg::OP_IMM), row_pc + 32'h1234_5000);
    // x0 stays zero
    silent_row(i_type(12'd7, 5'd1, r5p_pkg::ADD, 5'd0, r5p_pkg::OP_IMM));
    wb_row(r_type(7'h00, 5'd28, 5'd0, r5p_pkg::ADD, 5'd31), 32'hABCD_E000);
    // load and store address only
    mem_row(i_type(12'd8, 5'd3, 3'b010, 5'd30, r5p_pkg::LOAD), 1'b0, 32'h0000_0807);
    mem_row(s_type(-12'sd4, 5'd2, 5'd1, 3'b010), 1'b1, 32'h0000_0001);
    // link written by jalr
    wb_row(i_type(12'd0, 5'd27, r5p_pkg::ADD, 5'd31, r5p_pkg::OP_IMM), link_pc);
  endtask

  ////////////////////////////////////////////////////////////
  // clock, timeout and row pipeline
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= RST_CYCLES + n_rows + SLACK_CYCLES) begin
      $display("timeout: results missing after %0d cycles, %0d of %0d rows checked",
               cycles, rows_seen, n_rows);
      $display("Simulation failed");
      $finish;
    end
  end

  // outputs trail the stimulus by one edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chk_vld <= 1'b0;
      chk_idx <= 0;
    end else begin
      chk_vld <= cur_vld;
      chk_idx <= cur_idx;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    arst_n   = 1'b1;
    inst_vld = 1'b0;
    inst     = '0;
    pc       = '0;
    cur_vld  = 1'b0;
    cur_idx  = 0;
    cycles   = 0;
    build_table();
    // falling edge after time zero clears the flops
    #1 arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    // one row per cycle, no back-pressure
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      inst_vld <= 1'b1;
      inst     <= t_inst[i];
      pc       <= t_pc[i];
      cur_vld  <= 1'b1;
      cur_idx  <= i;
    end
    @(posedge clk);
    inst_vld <= 1'b0;
    inst     <= '0;
    cur_vld  <= 1'b0;
    wait (rows_seen == n_rows);
    // a few idle cycles for the strobes to drop
    repeat (3) @(posedge clk);
    $display("%0d rows checked, %0d passed, %0d failed, %0d idle errors, %0d assert errors",
             rows_seen, rows_pass, rows_fail, idle_err, uut.u_assert.fail_cnt);
    if ((rows_fail == 0) && (idle_err == 0) && (rows_pass == n_rows) &&
        (uut.u_assert.fail_cnt == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule: r5p_execute_tb
